//--- sim.f
rtl/mips_pkg.sv
rtl/mips_regfile.sv
rtl/mips_exec_unit.sv
rtl/mips_mem_unit.sv
rtl/mips_control.sv
rtl/mips_cpu_bus.sv
dv/tb_clock.sv
dv/avalon_mem_model.sv
dv/mips_cpu_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wall -Wno-fatal -f sim.f \
    --top-module mips_cpu_bus_tb -o mips_cpu_bus_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mips_cpu_bus_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "No final result in $LOG"
    exit 1
fi
exit 0

//--- dv/mips_cpu_bus_tb.sv
`default_nettype none

module mips_cpu_bus_tb import mips_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t RESET_PC = 32'hBFC0_0000;
    localparam word_t DATA_IN  = 32'h0000_1100;

    logic     clk;
    logic     reset;
    logic     random_mode;
    logic     active;
    word_t    register_v0;
    word_t    address;
    logic     write;
    logic     read;
    word_t    writedata;
    byte_en_t byteenable;
    logic     waitrequest;
    word_t    readdata;
    word_t    last_wr_addr;
    word_t    last_wr_data;
    logic     hold_error;

    word_t    prog[$];
    word_t    exp_addr[$];
    word_t    exp_val[$];
    string    exp_name[$];
    byte_en_t be_seen[$];
    byte_en_t be_exp[$];
    string    test_name;
    word_t    first_read_addr;
    logic     first_pending;
    logic     active_at_start;
    logic     idle_read_seen;
    longint   cycle_count;
    longint   cycle_budget;

    tb_clock u_clock (.clk(clk));

    mips_cpu_bus #(.RESET_PC(RESET_PC)) u_dut (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata)
    );

    avalon_mem_model u_mem (
        .clk(clk), .reset(reset), .random_mode(random_mode), .address(address),
        .read(read), .write(write), .writedata(writedata), .byteenable(byteenable),
        .waitrequest(waitrequest), .readdata(readdata), .last_wr_addr(last_wr_addr),
        .last_wr_data(last_wr_data), .hold_error(hold_error)
    );

    function automatic word_t enc_r(funct_t f, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                    logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, f};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(opcode_t op, word_t target);
        return {op, target[27:2]};
    endfunction

    function automatic word_t byte_ext(word_t w, int k, bit sgn);
        logic [7:0] b;
        b = w[8*k +: 8];
        return sgn ? {{24{b[7]}}, b} : {24'h000000, b};
    endfunction

    // Two's complement order, a set sign bit puts a word below every non-negative one
    function automatic word_t less_signed(word_t x, word_t y);
        if (x[31] != y[31]) begin
            return word_t'(x[31]);
        end
        return word_t'(x < y);
    endfunction

    // Logical shift with the vacated upper bits filled from the sign bit
    function automatic word_t shift_right_arith(word_t x, int n);
        word_t fill;
        fill = x[31] ? ~(32'hFFFF_FFFF >> n) : 32'h0000_0000;
        return (x >> n) | fill;
    endfunction

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "test %s stopped", test_name);
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_byte_en(string name, byte_en_t exp, byte_en_t act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %b, actual %b", test_name, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %b, actual %b", test_name, name, exp, act);
            stop_with_failure();
        end
    endtask

    // Monitor for the first fetch, data-read byte enables and reads after halt
    always @(posedge clk) begin
        if (reset) begin
            first_pending  <= 1'b1;
            idle_read_seen <= 1'b0;
        end else begin
            if (read && !waitrequest) begin
                if (first_pending) begin
                    first_read_addr <= address;
                    active_at_start <= active;
                    first_pending   <= 1'b0;
                end
                if (address >= DATA_IN && address < DATA_IN + 8) begin
                    be_seen.push_back(byteenable);
                end
            end
            if (!active && read) begin
                idle_read_seen <= 1'b1;
            end
        end
    end

    // Watchdog budget grows with every program that is run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_budget) begin
            $display("Watchdog expired in test %s, the CPU did not halt", test_name);
            stop_with_failure();
        end
    end

    task automatic begin_test(string name);
        test_name = name;
        prog.delete();
        exp_addr.delete();
        exp_val.delete();
        exp_name.delete();
        be_seen.delete();
        be_exp.delete();
        u_mem.clear();
    endtask

    task automatic add_halt();
        prog.push_back(enc_r(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
        prog.push_back(32'h0000_0000);
    endtask

    // Store a register to the next result slot at 0x1200 and expect a value
    task automatic store_result(reg_idx_t r, string name, word_t exp);
        logic [15:0] off;
        off = 16'h0200 + 16'(4 * exp_addr.size());
        prog.push_back(enc_i(OP_SW, 5'd8, r, off));
        exp_addr.push_back(32'h1000 + word_t'(off));
        exp_val.push_back(exp);
        exp_name.push_back(name);
    endtask

    task automatic calc(word_t instr, string name, word_t exp);
        prog.push_back(instr);
        store_result(5'd4, name, exp);
    endtask

    task automatic run_program(bit rnd);
        cycle_budget += prog.size() * 40 + 20;
        foreach (prog[i]) begin
            u_mem.load_word(RESET_PC + 4 * i, prog[i]);
        end
        random_mode <= rnd;
        reset       <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        do begin
            @(posedge clk);
        end while (active);
        repeat (10) @(posedge clk);
        foreach (exp_addr[i]) begin
            check_word(exp_name[i], exp_val[i], u_mem.peek_word(exp_addr[i]));
        end
        // The final store of a program is the last write on the bus
        if (exp_addr.size() > 0) begin
            check_word("last write address", exp_addr[$], last_wr_addr);
            check_word("last write data", exp_val[$], last_wr_data);
        end
        check_bit("request held under waitrequest", 1'b0, hold_error);
        check_bit("no reads after halt", 1'b0, idle_read_seen);
    endtask

    task automatic test_reset_halt();
        begin_test("reset_halt");
        add_halt();
        run_program(1'b0);
        check_word("first fetch address", RESET_PC, first_read_addr);
        check_bit("active after reset", 1'b1, active_at_start);
        check_bit("active after halt", 1'b0, active);
    endtask

    task automatic test_arith(bit rnd);
        word_t a;
        word_t b;
        word_t base;
        a    = 32'h8000_0005;
        b    = 32'hFFFF_FFF9;
        base = 32'h0000_1000;
        begin_test(rnd ? "arith_wait" : "arith");
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd8, 16'h1000));
        prog.push_back(enc_i(OP_LUI, 5'd0, 5'd1, 16'h8000));
        prog.push_back(enc_i(OP_ORI, 5'd1, 5'd1, 16'h0005));
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd3, 16'hFFF9));
        calc(enc_r(FN_ADDU, 5'd1, 5'd3, 5'd4, 5'd0), "addu", a + b);
        calc(enc_r(FN_SUBU, 5'd1, 5'd3, 5'd4, 5'd0), "subu", a - b);
        calc(enc_r(FN_AND, 5'd1, 5'd3, 5'd4, 5'd0), "and", a & b);
        calc(enc_r(FN_OR, 5'd1, 5'd3, 5'd4, 5'd0), "or", a | b);
        calc(enc_r(FN_XOR, 5'd1, 5'd3, 5'd4, 5'd0), "xor", a ^ b);
        // Negative a against the positive base tells signed from unsigned order
        calc(enc_r(FN_SLT, 5'd1, 5'd8, 5'd4, 5'd0), "slt", less_signed(a, base));
        calc(enc_r(FN_SLTU, 5'd1, 5'd8, 5'd4, 5'd0), "sltu", word_t'(a < base));
        calc(enc_r(FN_SLL, 5'd0, 5'd1, 5'd4, 5'd4), "sll", a << 4);
        calc(enc_r(FN_SRL, 5'd0, 5'd1, 5'd4, 5'd4), "srl", a >> 4);
        calc(enc_r(FN_SRA, 5'd0, 5'd1, 5'd4, 5'd4), "sra", shift_right_arith(a, 4));
        calc(enc_i(OP_ADDIU, 5'd1, 5'd4, 16'h8001), "addiu", a + 32'hFFFF_8001);
        calc(enc_i(OP_SLTI, 5'd1, 5'd4, 16'h0010), "slti", less_signed(a, 32'd16));
        calc(enc_i(OP_SLTI, 5'd3, 5'd4, 16'hFFF0), "slti neg",
             less_signed(b, 32'hFFFF_FFF0));
        calc(enc_i(OP_ANDI, 5'd3, 5'd4, 16'hF0F0), "andi", b & 32'h0000_F0F0);
        calc(enc_i(OP_ORI, 5'd1, 5'd4, 16'h8001), "ori", a | 32'h0000_8001);
        calc(enc_i(OP_XORI, 5'd3, 5'd4, 16'hFFFF), "xori", b ^ 32'h0000_FFFF);
        calc(enc_i(OP_LUI, 5'd0, 5'd4, 16'h1234), "lui", 32'h1234_0000);
        prog.push_back(enc_r(FN_SUBU, 5'd3, 5'd1, 5'd2, 5'd0));
        add_halt();
        run_program(rnd);
        check_word("register_v0", b - a, register_v0);
    endtask

    task automatic test_loads(bit rnd);
        word_t w[2];
        w[0] = 32'h8001_7F80;
        w[1] = 32'h7FFE_8001;
        begin_test(rnd ? "loads_wait" : "loads");
        u_mem.load_word(DATA_IN, w[0]);
        u_mem.load_word(DATA_IN + 4, w[1]);
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd8, 16'h1000));
        for (int k = 0; k < 2; k++) begin
            prog.push_back(enc_i(OP_LW, 5'd8, 5'd5, 16'h0100 + 16'(4 * k)));
            store_result(5'd5, $sformatf("lw %0d", k), w[k]);
            be_exp.push_back(4'b1111);
        end
        for (int k = 0; k < 8; k++) begin
            prog.push_back(enc_i(OP_LB, 5'd8, 5'd5, 16'h0100 + 16'(k)));
            store_result(5'd5, $sformatf("lb %0d", k), byte_ext(w[k/4], k % 4, 1'b1));
            prog.push_back(enc_i(OP_LBU, 5'd8, 5'd6, 16'h0100 + 16'(k)));
            store_result(5'd6, $sformatf("lbu %0d", k), byte_ext(w[k/4], k % 4, 1'b0));
            be_exp.push_back(byte_en_t'(1 << (k % 4)));
            be_exp.push_back(byte_en_t'(1 << (k % 4)));
        end
        add_halt();
        run_program(rnd);
        check_word("load read count", word_t'(be_exp.size()), word_t'(be_seen.size()));
        foreach (be_exp[i]) begin
            check_byte_en($sformatf("load %0d byteenable", i), be_exp[i], be_seen[i]);
        end
    endtask

    // Branch at i, delay slot at i+1, skipped at i+2, target at i+3
    task automatic branch_case(word_t br, bit taken, string name, bit link);
        word_t br_pc;
        br_pc = RESET_PC + 4 * prog.size();
        prog.push_back(br);
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd12, 16'h0011));
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd13, 16'h0022));
        store_result(5'd12, {name, " slot"}, 32'h11);
        store_result(5'd13, {name, " after slot"}, taken ? 32'h0 : 32'h22);
        if (link) begin
            store_result(5'd31, {name, " ra"}, br_pc + 8);
        end
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd12, 16'h0000));
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd13, 16'h0000));
    endtask

    task automatic test_branches(bit rnd);
        word_t target;
        begin_test(rnd ? "branch_wait" : "branch");
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd8, 16'h1000));
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd10, 16'h0005));
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd11, 16'h0005));
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd14, 16'h0006));
        branch_case(enc_i(OP_BEQ, 5'd10, 5'd11, 16'h0002), 1'b1, "beq taken", 1'b0);
        branch_case(enc_i(OP_BEQ, 5'd10, 5'd14, 16'h0002), 1'b0, "beq not taken", 1'b0);
        branch_case(enc_i(OP_BNE, 5'd10, 5'd14, 16'h0002), 1'b1, "bne taken", 1'b0);
        branch_case(enc_i(OP_BNE, 5'd10, 5'd11, 16'h0002), 1'b0, "bne not taken", 1'b0);
        target = RESET_PC + 4 * (prog.size() + 3);
        branch_case(enc_j(OP_J, target), 1'b1, "j", 1'b0);
        target = RESET_PC + 4 * (prog.size() + 3);
        branch_case(enc_j(OP_JAL, target), 1'b1, "jal", 1'b1);
        prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'h0077));
        add_halt();
        run_program(rnd);
        check_word("register_v0", 32'h77, register_v0);
    endtask

    initial begin
        reset        = 1'b1;
        random_mode  = 1'b0;
        cycle_count  = 0;
        cycle_budget = 0;
        void'($urandom(32'hc195_0b91));
        test_reset_halt();
        for (int rnd = 0; rnd < 2; rnd++) begin
            test_arith(rnd[0]);
            test_loads(rnd[0]);
            test_branches(rnd[0]);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/avalon_mem_model.sv
`default_nettype none

module avalon_mem_model import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     random_mode,
    input  word_t    address,
    input  logic     read,
    input  logic     write,
    input  word_t    writedata,
    input  byte_en_t byteenable,
    output logic     waitrequest,
    output word_t    readdata,
    output word_t    last_wr_addr,
    output word_t    last_wr_data,
    output logic     hold_error
);

    timeunit 1ns;
    timeprecision 1ps;

    word_t       mem [word_t];
    int unsigned wait_cnt;
    int unsigned wait_len;
    logic        holding;
    bus_req_t    held;
    bus_req_t    cur;
    word_t       merged;

    assign cur         = '{address, read, write, writedata, byteenable};
    assign waitrequest = (read || write) && (wait_cnt < wait_len);

    // Unwritten words return a pattern built from the whole address
    function automatic word_t peek_word(word_t addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5a5a_c3c3;
    endfunction

    task automatic load_word(word_t addr, word_t data);
        mem[addr[31:2]] = data;
    endtask

    task automatic clear();
        mem.delete();
    endtask

    always_comb begin
        readdata = peek_word(address);
    end

    always @(posedge clk) begin
        if (!reset && write && !waitrequest) begin
            merged = peek_word(address);
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    merged[8*b +: 8] = writedata[8*b +: 8];
                end
            end
            mem[address[31:2]] = merged;
            last_wr_addr <= address;
            last_wr_data <= merged;
        end
    end

    // Stall length per request, and a request must not move while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt   <= 0;
            wait_len   <= 0;
            holding    <= 1'b0;
            hold_error <= 1'b0;
        end else begin
            if (holding && cur != held) begin
                hold_error <= 1'b1;
            end
            if (waitrequest) begin
                wait_cnt <= wait_cnt + 1;
                holding  <= 1'b1;
                held     <= cur;
            end else if (read || write) begin
                wait_cnt <= 0;
                wait_len <= random_mode ? $urandom_range(3, 0) : 0;
                holding  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam realtime HALF_PERIOD = 5ns;

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- rtl/mips_cpu_bus.sv
`default_nettype none

module mips_cpu_bus import mips_pkg::*; #(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic     clk,
    input  logic     reset,
    output logic     active,
    output word_t    register_v0,

    // Avalon master
    output word_t    address,
    output logic     write,
    output logic     read,
    output word_t    writedata,
    output byte_en_t byteenable,
    input  logic     waitrequest,
    input  word_t    readdata
);

    bus_req_t  bus;
    instr_t    instr;
    word_t     pc;
    word_t     rs_val;
    word_t     rt_val;
    word_t     alu_result;
    logic      wb_en;
    reg_idx_t  wb_idx;
    logic      branch_taken;
    word_t     branch_target;
    logic      is_load;
    data_req_t data_req;
    word_t     load_value;
    logic      we;
    reg_idx_t  waddr;
    word_t     wdata;

    assign address    = bus.address;
    assign write      = bus.write;
    assign read       = bus.read;
    assign writedata  = bus.writedata;
    assign byteenable = bus.byteenable;

    mips_control #(
        .RESET_PC(RESET_PC)
    ) u_control (
        .clk          (clk),
        .reset        (reset),
        .waitrequest  (waitrequest),
        .readdata     (readdata),
        .bus          (bus),
        .active       (active),
        .instr        (instr),
        .alu_result   (alu_result),
        .wb_en        (wb_en),
        .wb_idx       (wb_idx),
        .branch_taken (branch_taken),
        .branch_target(branch_target),
        .is_load      (is_load),
        .data_req     (data_req),
        .load_value   (load_value),
        .pc           (pc),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata)
    );

    mips_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr_a(instr.rs),
        .raddr_b(instr.rt),
        .rdata_a(rs_val),
        .rdata_b(rt_val),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata),
        .v0     (register_v0)
    );

    mips_exec_unit u_exec (
        .instr        (instr),
        .pc           (pc),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .alu_result   (alu_result),
        .wb_en        (wb_en),
        .wb_idx       (wb_idx),
        .branch_taken (branch_taken),
        .branch_target(branch_target),
        .is_load      (is_load)
    );

    mips_mem_unit u_mem (
        .instr     (instr),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .readdata  (readdata),
        .data_req  (data_req),
        .load_value(load_value)
    );

endmodule

`default_nettype wire

//--- rtl/mips_control.sv
`default_nettype none

module mips_control import mips_pkg::*; #(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      waitrequest,
    input  word_t     readdata,
    output bus_req_t  bus,
    output logic      active,
    output instr_t    instr,
    input  word_t     alu_result,
    input  logic      wb_en,
    input  reg_idx_t  wb_idx,
    input  logic      branch_taken,
    input  word_t     branch_target,
    input  logic      is_load,
    input  data_req_t data_req,
    input  word_t     load_value,
    output word_t     pc,
    output logic      we,
    output reg_idx_t  waddr,
    output word_t     wdata
);

    cpu_state_t state;
    instr_t     ir;
    word_t      delay_target;
    logic       delay_flag;
    logic       is_store;
    logic       fetch_halt;
    logic       retire;
    word_t      next_pc;

    assign instr      = ir;
    assign is_store   = (ir.opcode == OP_SW);
    assign fetch_halt = (pc == '0);

    // Delay slot done, so follow the stored jump
    assign next_pc = delay_flag ? delay_target : pc + 32'd4;

    // Instruction leaves its last state this cycle
    always_comb begin
        retire = 1'b0;
        if (state == EXEC) begin
            if (is_store) begin
                retire = !waitrequest;
            end else begin
                retire = !is_load;
            end
        end else if (state == MEM_ACCESS) begin
            retire = !waitrequest;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FETCH;
            active     <= 1'b1;
            pc         <= RESET_PC;
            delay_flag <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (fetch_halt) begin
                        state  <= HALTED;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (is_load) begin
                        state <= MEM_ACCESS;
                    end else if (retire) begin
                        state <= FETCH;
                    end
                end
                MEM_ACCESS: begin
                    if (retire) begin
                        state <= FETCH;
                    end
                end
                default: begin
                    state <= HALTED;
                end
            endcase
            if (retire) begin
                pc         <= next_pc;
                delay_flag <= branch_taken;
            end
        end
    end

    // Instruction capture and the pending jump target
    always_ff @(posedge clk) begin
        if (state == FETCH && !fetch_halt && !waitrequest) begin
            ir <= readdata;
        end
        if (retire && branch_taken) begin
            delay_target <= branch_target;
        end
    end

    // One bus request at a time, chosen by state
    always_comb begin
        bus = '0;
        case (state)
            FETCH: begin
                bus.address    = pc;
                bus.read       = !fetch_halt;
                bus.byteenable = BE_WORD;
            end
            EXEC: begin
                if (is_store) begin
                    bus.address    = data_req.address;
                    bus.write      = 1'b1;
                    bus.writedata  = data_req.writedata;
                    bus.byteenable = data_req.byteenable;
                end
            end
            MEM_ACCESS: begin
                bus.address    = data_req.address;
                bus.read       = 1'b1;
                bus.byteenable = data_req.byteenable;
            end
            default: begin
                bus = '0;
            end
        endcase
    end

    // Loads write back on read acceptance, the rest at the end of EXEC
    assign we    = (state == EXEC && wb_en && !is_load) || (state == MEM_ACCESS && !waitrequest);
    assign waddr = wb_idx;
    assign wdata = (state == MEM_ACCESS) ? load_value : alu_result;

endmodule

`default_nettype wire

//--- rtl/mips_mem_unit.sv
`default_nettype none

module mips_mem_unit import mips_pkg::*; (
    input  instr_t    instr,
    input  word_t     rs_val,
    input  word_t     rt_val,
    input  word_t     readdata,
    output data_req_t data_req,
    output word_t     load_value
);

    word_t      eff_addr;
    logic [1:0] offset;
    logic       byte_access;
    logic [7:0] sel_byte;

    assign eff_addr    = rs_val + sign_ext_imm(instr);
    assign offset      = eff_addr[1:0];
    assign byte_access = (instr.opcode == OP_LB) || (instr.opcode == OP_LBU);

    // Bus is word addressed, byte lanes pick the part
    always_comb begin
        data_req.address   = {eff_addr[WORD_W-1:2], 2'b00};
        data_req.writedata = rt_val;
        if (byte_access) begin
            data_req.byteenable = byte_en_t'(4'b0001 << offset);
        end else begin
            data_req.byteenable = BE_WORD;
        end
    end

    // Byte lane selected by the low address bits
    always_comb begin
        case (offset)
            2'd0:    sel_byte = readdata[7:0];
            2'd1:    sel_byte = readdata[15:8];
            2'd2:    sel_byte = readdata[23:16];
            default: sel_byte = readdata[31:24];
        endcase
    end

    always_comb begin
        case (instr.opcode)
            OP_LB:   load_value = {{24{sel_byte[7]}}, sel_byte};
            OP_LBU:  load_value = {24'h000000, sel_byte};
            default: load_value = readdata;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mips_exec_unit.sv
`default_nettype none

module mips_exec_unit import mips_pkg::*; (
    input  instr_t   instr,
    input  word_t    pc,
    input  word_t    rs_val,
    input  word_t    rt_val,
    output word_t    alu_result,
    output logic     wb_en,
    output reg_idx_t wb_idx,
    output logic     branch_taken,
    output word_t    branch_target,
    output logic     is_load
);

    word_t simm;
    word_t zimm;
    word_t pc_plus4;
    word_t pc_plus8;
    word_t jump_target;

    assign simm        = sign_ext_imm(instr);
    assign zimm        = {{(WORD_W-IMM_W){1'b0}}, imm_field(instr)};
    assign pc_plus4    = pc + 32'd4;
    assign pc_plus8    = pc + 32'd8;
    assign jump_target = {pc_plus4[31:28], instr.rs, instr.rt, imm_field(instr), 2'b00};

    always_comb begin
        alu_result    = '0;
        wb_en         = 1'b0;
        wb_idx        = instr.rt;
        branch_taken  = 1'b0;
        branch_target = pc_plus4 + {simm[29:0], 2'b00};
        is_load       = 1'b0;

        case (instr.opcode)
            OP_SPECIAL: begin
                wb_idx = instr.rd;
                wb_en  = 1'b1;
                case (instr.funct)
                    FN_ADDU: alu_result = rs_val + rt_val;
                    FN_SUBU: alu_result = rs_val - rt_val;
                    FN_AND:  alu_result = rs_val & rt_val;
                    FN_OR:   alu_result = rs_val | rt_val;
                    FN_XOR:  alu_result = rs_val ^ rt_val;
                    FN_SLT:  alu_result = word_t'($signed(rs_val) < $signed(rt_val));
                    FN_SLTU: alu_result = word_t'(rs_val < rt_val);
                    FN_SLL:  alu_result = rt_val << instr.shamt;
                    FN_SRL:  alu_result = rt_val >> instr.shamt;
                    FN_SRA:  alu_result = $signed(rt_val) >>> instr.shamt;
                    FN_JR: begin
                        wb_en         = 1'b0;
                        branch_taken  = 1'b1;
                        branch_target = rs_val;
                    end
                    default: wb_en = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_result = rs_val + simm;
                wb_en      = 1'b1;
            end
            OP_SLTI: begin
                alu_result = word_t'($signed(rs_val) < $signed(simm));
                wb_en      = 1'b1;
            end
            OP_ANDI: begin
                alu_result = rs_val & zimm;
                wb_en      = 1'b1;
            end
            OP_ORI: begin
                alu_result = rs_val | zimm;
                wb_en      = 1'b1;
            end
            OP_XORI: begin
                alu_result = rs_val ^ zimm;
                wb_en      = 1'b1;
            end
            OP_LUI: begin
                alu_result = {imm_field(instr), 16'h0000};
                wb_en      = 1'b1;
            end
            OP_LB, OP_LBU, OP_LW: begin
                wb_en   = 1'b1;
                is_load = 1'b1;
            end
            OP_BEQ: branch_taken = (rs_val == rt_val);
            OP_BNE: branch_taken = (rs_val != rt_val);
            OP_J: begin
                branch_taken  = 1'b1;
                branch_target = jump_target;
            end
            OP_JAL: begin
                branch_taken  = 1'b1;
                branch_target = jump_target;
                // Return past the delay slot
                alu_result    = pc_plus8;
                wb_en         = 1'b1;
                wb_idx        = REG_RA;
            end
            default: wb_en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mips_regfile.sv
`default_nettype none

module mips_regfile import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output word_t    rdata_a,
    output word_t    rdata_b,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    output word_t    v0
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Register zero is never written so it reads back as zero
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];
    assign v0      = regs[REG_V0];

endmodule

`default_nettype wire

//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int BYTE_EN_W = 4;
    localparam int IMM_W     = 16;
    localparam int NUM_REGS  = 32;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [BYTE_EN_W-1:0] byte_en_t;

    localparam reg_idx_t REG_V0  = 5'd2;
    localparam reg_idx_t REG_RA  = 5'd31;
    localparam byte_en_t BE_WORD = 4'b1111;

    // Major opcodes that the core executes, everything else is a no-op
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_SW      = 6'h2b
    } opcode_t;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_ACCESS,
        HALTED
    } cpu_state_t;

    // R-type view of an instruction word
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic [4:0] shamt;
        funct_t   funct;
    } instr_t;

    typedef struct packed {
        word_t    address;
        logic     read;
        logic     write;
        word_t    writedata;
        byte_en_t byteenable;
    } bus_req_t;

    typedef struct packed {
        word_t    address;
        byte_en_t byteenable;
        word_t    writedata;
    } data_req_t;

    // I-type immediate sits in the low half of the word
    function automatic logic [IMM_W-1:0] imm_field(instr_t i);
        return {i.rd, i.shamt, i.funct};
    endfunction

    function automatic word_t sign_ext_imm(instr_t i);
        logic [IMM_W-1:0] imm;
        imm = imm_field(i);
        return {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
    endfunction

endpackage

`default_nettype wire
